// File: hdl/jfive_cfg_pkg.sv
// Front end configuration for the four-thread barrel core
// Mode codes follow funct3 of the RISC-V branch group, with JAL and JALR in the gaps
package jfive_cfg_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int THREADS    = 4;
    localparam int ID_BITS    = 2;      // Enough for THREADS
    localparam int PC_BITS    = 32;
    localparam int PHASE_BITS = 2;

    typedef logic [ID_BITS-1:0]    id_t;
    typedef logic [PC_BITS-1:0]    pc_t;
    typedef logic [PHASE_BITS-1:0] phase_t;
    typedef logic [2:0]            mode_t;

    // Every thread starts here after reset
    localparam pc_t RESET_PC = 32'h8000_0000;

    // --------------------------------------------------
    // Branch mode codes
    // --------------------------------------------------
    localparam mode_t MODE_BEQ  = 3'b000;
    localparam mode_t MODE_BNE  = 3'b001;
    localparam mode_t MODE_JAL  = 3'b010;
    localparam mode_t MODE_JALR = 3'b011;
    localparam mode_t MODE_BLT  = 3'b100;
    localparam mode_t MODE_BGE  = 3'b101;
    localparam mode_t MODE_BLTU = 3'b110;
    localparam mode_t MODE_BGEU = 3'b111;

endpackage

// File: hdl/jfive_msg_pkg.sv
// Messages passed between the front end blocks
// All structs are packed, first field in the MSBs
package jfive_msg_pkg;

    import jfive_cfg_pkg::*;

    // One issued fetch, 37 bits
    typedef struct packed {
        id_t    id;
        pc_t    pc;
        phase_t phase;     // Phase of the thread at issue
        logic   valid;
    } fetch_t;

    // Result handed back by execute
    typedef struct packed {
        id_t    id;
        pc_t    pc;
        phase_t phase;
        mode_t  mode;
        logic   eq;
        logic   carry;
        logic   msb_c;     // Carry into the MSB
        logic   sign;
        pc_t    imm_pc;    // pc + imm
        pc_t    jalr_pc;   // rs1 + imm
        logic   valid;
    } exec_t;

    // Taken control transfer
    typedef struct packed {
        id_t  id;
        pc_t  old_pc;
        pc_t  pc;          // Target
        logic valid;
    } redirect_t;

    // PC table write request
    typedef struct packed {
        id_t  id;
        pc_t  pc;
        logic req;
    } pc_wr_t;

endpackage

// File: hdl/jfive_thread_pc_table.sv
// Next PC of each thread; read is asynchronous, write lands on the clock edge
// Caller must gate wr.req with its clock enable
module jfive_thread_pc_table
    import jfive_cfg_pkg::*;
    import jfive_msg_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  pc_wr_t wr,
    input  id_t    rd_id,
    output pc_t    rd_pc
);

    pc_t pc_regs [THREADS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < THREADS; i++) begin
                pc_regs[i] <= RESET_PC;
            end
        end else if (wr.req) begin
            pc_regs[wr.id] <= wr.pc;   // Granted write from the arbiter
        end
    end

    // Combinational read for the sequencer
    assign rd_pc = pc_regs[rd_id];

endmodule

// File: hdl/jfive_pc_write_arbiter.sv
// Fixed priority, redirect first; purely combinational
module jfive_pc_write_arbiter
    import jfive_msg_pkg::*;
(
    input  pc_wr_t seq,
    input  pc_wr_t redir,
    output pc_wr_t wr,
    output logic   seq_grant,
    output logic   redir_grant
);

    // --------------------------------------------------
    // Grants
    // --------------------------------------------------
    always_comb begin
        redir_grant = redir.req;
        seq_grant   = seq.req && !redir.req;   // Loses to any redirect
    end

    // --------------------------------------------------
    // Write port mux
    // --------------------------------------------------
    always_comb begin
        if (redir.req) begin
            wr = redir;
        end else begin
            wr = seq;                          // req low when idle
        end
    end

endmodule

// File: hdl/jfive_fetch_sequencer.sv
// Round-robin fetch issue, one thread per granted cycle
// A missing grant holds the pointer, so the same thread is retried
module jfive_fetch_sequencer
    import jfive_cfg_pkg::*;
    import jfive_msg_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cke,
    input  pc_t                    rd_pc,
    input  phase_t [THREADS-1:0]   phase_table,
    input  logic                   grant,
    output id_t                    rd_id,
    output pc_wr_t                 wr,
    output fetch_t                 fetch
);

    id_t    cur_id;
    logic   fetch_valid;
    id_t    fetch_id;
    pc_t    fetch_pc;
    phase_t fetch_phase;

    // --------------------------------------------------
    // Sequential PC write request
    // --------------------------------------------------
    assign rd_id  = cur_id;
    assign wr.id  = cur_id;
    assign wr.pc  = rd_pc + pc_t'(4);
    assign wr.req = cke;               // Every enabled cycle

    // Thread pointer and valid
    always_ff @(posedge clk) begin
        if (reset) begin
            cur_id      <= '0;
            fetch_valid <= 1'b0;
        end else if (cke) begin
            fetch_valid <= grant;
            if (grant) begin
                cur_id <= (cur_id == id_t'(THREADS - 1)) ? '0 : cur_id + id_t'(1);
            end
        end
    end

    // Fetch payload, captured only on a granted issue
    always_ff @(posedge clk) begin
        if (cke && grant) begin
            fetch_id    <= cur_id;
            fetch_pc    <= rd_pc;
            fetch_phase <= phase_table[cur_id];
        end
    end

    assign fetch.id    = fetch_id;
    assign fetch.pc    = fetch_pc;
    assign fetch.phase = fetch_phase;
    assign fetch.valid = fetch_valid;

endmodule

// File: hdl/jfive_branch_unit.sv
// Evaluates execute results and redirects the thread one cycle later
// Results tagged with a phase other than the current one are dropped
module jfive_branch_unit
    import jfive_cfg_pkg::*;
    import jfive_msg_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cke,
    input  exec_t                  exec,
    output phase_t [THREADS-1:0]   phase_table,
    output redirect_t              redirect,
    output pc_wr_t                 wr
);

    logic current;
    logic taken;
    logic redir_valid;
    id_t  redir_id;
    pc_t  redir_old_pc;
    pc_t  redir_pc;

    // --------------------------------------------------
    // Condition decode
    // --------------------------------------------------
    assign current = exec.valid && (exec.phase == phase_table[exec.id]);

    always_comb begin
        taken = 1'b0;
        if (current) begin
            case (exec.mode)
                MODE_BEQ:  taken =  exec.eq;
                MODE_BNE:  taken = !exec.eq;
                MODE_BLT:  taken =  (exec.carry ^ exec.msb_c ^ exec.sign);   // Signed lt
                MODE_BGE:  taken = !(exec.carry ^ exec.msb_c ^ exec.sign);
                MODE_BLTU: taken = !exec.carry;    // Borrow out
                MODE_BGEU: taken =  exec.carry;
                MODE_JAL:  taken = 1'b1;
                MODE_JALR: taken = 1'b1;
                default:   taken = 1'b0;
            endcase
        end
    end

    // --------------------------------------------------
    // Phase table and redirect register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            phase_table <= '0;
            redir_valid <= 1'b0;
        end else if (cke) begin
            if (taken) begin
                phase_table[exec.id] <= phase_table[exec.id] + phase_t'(1);
            end
            redir_valid <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (cke && taken) begin
            redir_id     <= exec.id;
            redir_old_pc <= exec.pc;
            redir_pc     <= (exec.mode == MODE_JALR) ? exec.jalr_pc : exec.imm_pc;
        end
    end

    assign redirect.id     = redir_id;
    assign redirect.old_pc = redir_old_pc;
    assign redirect.pc     = redir_pc;
    assign redirect.valid  = redir_valid;

    // PC write for the redirected thread, wins arbitration
    assign wr.id  = redir_id;
    assign wr.pc  = redir_pc;
    assign wr.req = redir_valid && cke;

endmodule

// File: hdl/jfive_frontend.sv
// Control flow front end, four threads fetched round robin
// No instruction memory here; fetch carries only id, pc and phase
module jfive_frontend
    import jfive_cfg_pkg::*;
    import jfive_msg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cke,
    input  exec_t     exec,
    output fetch_t    fetch,
    output redirect_t redirect
);

    pc_wr_t               seq_wr;
    pc_wr_t               redir_wr;
    pc_wr_t               table_wr;
    logic                 seq_grant;
    logic                 redir_grant;
    id_t                  rd_id;
    pc_t                  rd_pc;
    phase_t [THREADS-1:0] phase_table;

    // --------------------------------------------------
    // PC storage and its write port
    // --------------------------------------------------
    jfive_thread_pc_table i_pc_table (
        .clk   (clk),
        .reset (reset),
        .wr    (table_wr),
        .rd_id (rd_id),
        .rd_pc (rd_pc)
    );

    jfive_pc_write_arbiter i_pc_arb (
        .seq         (seq_wr),
        .redir       (redir_wr),
        .wr          (table_wr),
        .seq_grant   (seq_grant),
        .redir_grant (redir_grant)    // Always high with a request
    );

    jfive_fetch_sequencer i_seq (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .rd_pc       (rd_pc),
        .phase_table (phase_table),
        .grant       (seq_grant),
        .rd_id       (rd_id),
        .wr          (seq_wr),
        .fetch       (fetch)
    );

    jfive_branch_unit i_branch (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .exec        (exec),
        .phase_table (phase_table),
        .redirect    (redirect),
        .wr          (redir_wr)
    );

endmodule

// File: testbench/tb_chk.sv
// Assertions bound into the branch unit
// wr_grant is the arbiter's redirect grant from the enclosing front end
module tb_chk
    import jfive_cfg_pkg::*;
    import jfive_msg_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input logic                 cke,
    input phase_t [THREADS-1:0] phase_table,
    input redirect_t            redirect,
    input pc_wr_t               wr,
    input logic                 wr_grant
);
    timeunit 1ns;
    timeprecision 1ps;

    phase_t [THREADS-1:0] phase_prev;   // Phase table one enabled cycle back
    int                   fail_count = 0;

    always_ff @(posedge clk) begin
        if (cke) begin
            phase_prev <= phase_table;
        end
    end

    assert property (@(posedge clk) reset |=> !redirect.valid)
    else begin
        $error("redirect valid in the cycle after reset");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (reset) wr.req |-> wr_grant)
    else begin
        $error("redirect PC write request not granted");
        fail_count++;
    end

    // Redirect follows a phase step of its own thread
    assert property (@(posedge clk) disable iff (reset)
        cke && redirect.valid |-> phase_table[redirect.id] != phase_prev[redirect.id])
    else begin
        $error("redirect without a phase change of its thread");
        fail_count++;
    end

endmodule

// File: testbench/tb.sv
// Plays execute for the front end, stimulus and expected flags from testbench/jfive_cases.txt
// cke stays high; every current-phase fetch not executed is treated as sequential
module tb
    import jfive_cfg_pkg::*;
    import jfive_msg_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic      clk = 1'b0;
    logic      reset;
    logic      cke;
    exec_t     exec;
    fetch_t    fetch;
    redirect_t redirect;

    pc_t    model_pc    [THREADS];   // Next pc expected per thread
    phase_t model_phase [THREADS];
    id_t    exp_id;                  // Rotation order
    logic   hit;
    fetch_t hit_fetch;
    int     errors    = 0;
    int     checks    = 0;
    logic   timed_out = 1'b0;

    always #2 clk = ~clk;

    jfive_frontend i_dut (
        .clk      (clk),
        .reset    (reset),
        .cke      (cke),
        .exec     (exec),
        .fetch    (fetch),
        .redirect (redirect)
    );

    bind jfive_branch_unit tb_chk i_chk (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .phase_table (phase_table),
        .redirect    (redirect),
        .wr          (wr),
        .wr_grant    (tb.i_dut.redir_grant)
    );

    // --------------------------------------------------
    // Checks and fetch monitor
    // --------------------------------------------------
    task automatic expect_equal(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic observe_fetch();
        hit = 1'b0;
        if (fetch.valid === 1'b1) begin
            expect_equal(64'(fetch.id), 64'(exp_id), "fetch thread");
            exp_id = fetch.id + id_t'(1);
            if (fetch.phase == model_phase[fetch.id]) begin   // Stale fetches skipped
                expect_equal(64'(fetch.pc), 64'(model_pc[fetch.id]), "fetch pc");
                model_pc[fetch.id] = model_pc[fetch.id] + pc_t'(4);
                hit       = 1'b1;
                hit_fetch = fetch;
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        observe_fetch();
    endtask

    // Every thread must show one more current fetch after the last case
    task automatic wait_refetch_all();
        logic [THREADS-1:0] seen;
        int                 n;
        seen = '0;
        n = 0;
        while (seen != '1) begin
            if (n == 40) begin
                $display("Timeout: not every thread fetched again after the last case");
                timed_out = 1'b1;
                return;
            end
            next_cycle();
            n++;
            if (hit) begin
                seen[hit_fetch.id] = 1'b1;
            end
        end
    endtask

    function automatic logic branch_taken(input mode_t mode, input logic [3:0] f);
        case (mode)                         // f holds eq, carry, msb_c, sign
            MODE_BEQ:  return f[3];
            MODE_BNE:  return !f[3];
            MODE_BLT:  return f[2] ^ f[1] ^ f[0];
            MODE_BGE:  return !(f[2] ^ f[1] ^ f[0]);
            MODE_BLTU: return !f[2];
            MODE_BGEU: return f[2];
            default:   return 1'b1;         // JAL and JALR
        endcase
    endfunction

    // --------------------------------------------------
    // One case: find the fetch, execute it, check redirect
    // --------------------------------------------------
    task automatic run_case(input int num, input id_t t, input mode_t mode,
                            input logic [3:0] flags, input int imm, input pc_t jalr_pc);
        int    n;
        int    errs_before;
        logic  taken;
        pc_t   target;
        exec_t x;
        errs_before = errors;
        hit = 1'b0;
        n = 0;
        while (!(hit && hit_fetch.id == t)) begin
            if (n == 40) begin
                $display("Timeout: case %0d saw no current fetch of thread %0d", num, t);
                timed_out = 1'b1;
                return;
            end
            next_cycle();
            n++;
        end
        taken  = branch_taken(mode, flags);
        target = (mode == MODE_JALR) ? jalr_pc : hit_fetch.pc + pc_t'(imm);
        x = '0;
        x.id      = t;
        x.pc      = hit_fetch.pc;
        x.phase   = hit_fetch.phase;
        x.mode    = mode;
        {x.eq, x.carry, x.msb_c, x.sign} = flags;
        x.imm_pc  = hit_fetch.pc + pc_t'(imm);
        x.jalr_pc = jalr_pc;
        x.valid   = 1'b1;
        next_cycle();
        expect_equal(64'(redirect.valid), 64'd0, "redirect before exec");
        exec = x;
        if (taken) begin
            model_pc[t]    = target;
            model_phase[t] = model_phase[t] + phase_t'(1);
        end
        next_cycle();
        exec.valid = 1'b0;
        expect_equal(64'(redirect.valid), 64'(taken), "redirect valid");
        if (taken) begin
            expect_equal(64'(redirect.id), 64'(t), "redirect thread");
            expect_equal(64'(redirect.old_pc), 64'(x.pc), "redirect old pc");
            expect_equal(64'(redirect.pc), 64'(target), "redirect target");
            exec = x;                       // Same result again, now a stale phase
            next_cycle();
            exec.valid = 1'b0;
            expect_equal(64'(redirect.valid), 64'd0, "redirect from stale result");
        end
        $display("case %0d thread %0d mode %0d taken %0d: %s", num, t, mode, taken,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int    fd;
        int    n;
        int    num;
        int    t, mode, eq, c, mc, s, imm;
        pc_t   jalr;
        string line;
        reset  = 1'b1;
        cke    = 1'b1;
        exec   = '0;
        exp_id = '0;
        num    = 0;
        for (int i = 0; i < THREADS; i++) begin
            model_pc[i]    = RESET_PC;
            model_phase[i] = '0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        fd = $fopen("testbench/jfive_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/jfive_cases.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %h", t, mode, eq, c, mc, s, imm, jalr);
                if (n == 8) begin
                    num++;
                    run_case(num, id_t'(t), mode_t'(mode), {eq[0], c[0], mc[0], s[0]}, imm, jalr);
                end
            end
            $fclose(fd);
        end
        wait_refetch_all();                 // Covers the refetch after the last redirect
        errors += i_dut.i_branch.i_chk.fail_count;
        $display("%0d cases, %0d checks, %0d errors", num, checks, errors);
        if (errors == 0 && !timed_out && num > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/jfive_cases.txt
# thread mode(0 beq 1 bne 2 jal 3 jalr 4 blt 5 bge 6 bltu 7 bgeu) eq carry msb_c sign
# imm(signed decimal, target = fetch pc + imm) jalr_target(hex, used by jalr only)
0 0 1 0 0 0 64 00000000
1 0 0 1 0 0 64 00000000
2 1 0 0 0 0 -32 00000000
3 1 1 0 0 0 16 00000000
0 4 0 0 0 1 128 00000000
1 4 0 1 1 0 128 00000000
2 5 0 1 0 0 8 00000000
3 5 0 0 0 0 -8 00000000
0 6 0 0 0 0 256 00000000
1 6 0 1 0 0 256 00000000
2 7 0 1 0 0 12 00000000
3 7 0 0 0 0 12 00000000
0 2 0 0 0 0 -64 00000000
1 3 0 0 0 0 0 80001000
2 3 1 1 1 1 0 90000040
3 2 0 0 0 0 1024 00000000
0 0 1 0 0 0 4 00000000
1 1 1 1 0 1 -16 00000000

// File: tb.f
hdl/jfive_cfg_pkg.sv
hdl/jfive_msg_pkg.sv
hdl/jfive_thread_pc_table.sv
hdl/jfive_pc_write_arbiter.sv
hdl/jfive_fetch_sequencer.sv
hdl/jfive_branch_unit.sv
hdl/jfive_frontend.sv
testbench/tb_chk.sv
testbench/tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb
FILELIST := tb.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "TEST FAIL" $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
